// File: Makefile
TOP := tb_camera

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f rtl/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+verif
rtl/cam_pkg.sv
rtl/image_buffer.sv
rtl/buffer_arbiter.sv
rtl/frame_metering.sv
rtl/capture_ctrl.sv
rtl/cmd_decoder.sv
rtl/camera_top.sv
verif/tb_camera.sv

// File: rtl/buffer_arbiter.sv
/* Writer always wins the buffer port; a reader must hold its request until granted
   rd_valid follows rd_grant by exactly one cycle */
`timescale 1ns/1ps
`default_nettype none

module buffer_arbiter (
    input  logic                           clock_spi_in,
    input  logic                           mipi_byte_reset_n,
    input  logic                           wr_req_i,
    input  logic [cam_pkg::BUF_ADDR_W-1:0] wr_addr_i,
    input  logic [31:0]                    wr_data_i,
    input  logic                           rd_req_i,
    input  logic [cam_pkg::BUF_ADDR_W-1:0] rd_addr_i,
    output logic                           wr_grant_o,
    output logic                           rd_grant_o,
    output logic [31:0]                    rd_data_o,
    output logic                           rd_valid_o,
    output logic [cam_pkg::BUF_ADDR_W-1:0] mem_addr_o,
    output logic [31:0]                    mem_wdata_o,
    output logic                           mem_we_o,
    input  logic [31:0]                    mem_rdata_i
);

    assign wr_grant_o  = wr_req_i;
    assign rd_grant_o  = rd_req_i && !wr_req_i;   // Reads only in idle slots
    assign mem_addr_o  = wr_grant_o ? wr_addr_i : rd_addr_i;
    assign mem_wdata_o = wr_data_i;
    assign mem_we_o    = wr_grant_o;
    assign rd_data_o   = mem_rdata_i;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_grant_o;   // RAM read latency
        end
    end

    // A blocked read keeps its request and address for the next slot
    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        (rd_req_i && !rd_grant_o) |=> (rd_req_i && $stable(rd_addr_i)))
        else $error("Read request dropped or moved before its grant");

endmodule

`default_nettype wire

// File: rtl/cam_pkg.sv
/* Fixed capture geometry for a 16x8 raw frame; the crop window is not programmable
   Window columns and rows start on even values so the RGGB phase matches the sensor */
`default_nettype none

package cam_pkg;

    localparam int PIXEL_W = 10;           // Raw Bayer sample width

    // Command op-codes
    localparam logic [7:0] OP_CAPTURE  = 8'h20;
    localparam logic [7:0] OP_READ     = 8'h22;
    localparam logic [7:0] OP_METERING = 8'h25;
    localparam logic [7:0] OP_SIZE     = 8'h31;

    // Crop window, start inclusive, end exclusive
    localparam int CROP_X_START = 4;
    localparam int CROP_X_END   = 12;
    localparam int CROP_Y_START = 2;
    localparam int CROP_Y_END   = 6;

    localparam int BUF_ADDR_W = 6;         // 64 words of 32 bits
    localparam int BYTE_CNT_W = 16;

    // log2 of samples per channel in the window
    localparam int RED_SHIFT   = 3;        // 8 samples
    localparam int GREEN_SHIFT = 4;        // 16 samples
    localparam int BLUE_SHIFT  = 3;        // 8 samples

    localparam int X_W = 5;
    localparam int Y_W = 4;

endpackage

`default_nettype wire

// File: rtl/camera_top.sv
/* Single-clock capture subsystem; pixels arrive already deserialized on clock_spi_in */
`timescale 1ns/1ps
`default_nettype none

module camera_top (
    input  logic                        clock_spi_in,
    input  logic                        mipi_byte_reset_n,
    input  logic [7:0]                  op_code_i,
    input  logic                        op_code_valid_i,
    input  logic [7:0]                  operand_i,
    input  logic                        operand_valid_i,
    input  logic [7:0]                  operand_count_i,
    input  logic                        pixel_frame_valid_i,
    input  logic                        pixel_line_valid_i,
    input  logic [cam_pkg::PIXEL_W-1:0] pixel_data_i,
    output logic [7:0]                  response_o,
    output logic                        response_valid_o
);

    logic                           capture_start;
    logic                           capture_busy;
    logic [cam_pkg::BYTE_CNT_W-1:0] capture_bytes;
    logic [7:0]                     meter_red;
    logic [7:0]                     meter_green;
    logic [7:0]                     meter_blue;
    logic                           wr_req;
    logic [cam_pkg::BUF_ADDR_W-1:0] wr_addr;
    logic [31:0]                    wr_data;
    logic                           wr_grant;
    logic                           rd_req;
    logic [cam_pkg::BUF_ADDR_W-1:0] rd_addr;
    logic                           rd_grant;
    logic [31:0]                    rd_data;
    logic                           rd_valid;
    logic [cam_pkg::BUF_ADDR_W-1:0] mem_addr;
    logic [31:0]                    mem_wdata;
    logic                           mem_we;
    logic [31:0]                    mem_rdata;

    cmd_decoder u_cmd_decoder (
        .clock_spi_in, .mipi_byte_reset_n,
        .op_code_i, .op_code_valid_i, .operand_i, .operand_valid_i, .operand_count_i,
        .capture_busy_i(capture_busy), .capture_bytes_i(capture_bytes),
        .meter_red_i(meter_red), .meter_green_i(meter_green), .meter_blue_i(meter_blue),
        .rd_grant_i(rd_grant), .rd_data_i(rd_data), .rd_valid_i(rd_valid),
        .capture_start_o(capture_start), .rd_req_o(rd_req), .rd_addr_o(rd_addr),
        .response_o, .response_valid_o
    );

    capture_ctrl u_capture_ctrl (
        .clock_spi_in, .mipi_byte_reset_n,
        .capture_start_i(capture_start),
        .pixel_frame_valid_i, .pixel_line_valid_i, .pixel_data_i,
        .wr_grant_i(wr_grant),
        .capture_busy_o(capture_busy), .capture_bytes_o(capture_bytes),
        .wr_req_o(wr_req), .wr_addr_o(wr_addr), .wr_data_o(wr_data)
    );

    frame_metering u_frame_metering (
        .clock_spi_in, .mipi_byte_reset_n,
        .pixel_frame_valid_i, .pixel_line_valid_i, .pixel_data_i,
        .meter_red_o(meter_red), .meter_green_o(meter_green), .meter_blue_o(meter_blue)
    );

    buffer_arbiter u_buffer_arbiter (
        .clock_spi_in, .mipi_byte_reset_n,
        .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .rd_req_i(rd_req), .rd_addr_i(rd_addr),
        .wr_grant_o(wr_grant), .rd_grant_o(rd_grant),
        .rd_data_o(rd_data), .rd_valid_o(rd_valid),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_we_o(mem_we),
        .mem_rdata_i(mem_rdata)
    );

    image_buffer u_image_buffer (
        .clock_spi_in,
        .addr_i(mem_addr), .wdata_i(mem_wdata), .we_i(mem_we),
        .rdata_o(mem_rdata)
    );

endmodule

`default_nettype wire

// File: rtl/capture_ctrl.sv
/* Captures the first whole frame that starts after capture_start; a running frame is skipped
   Window bytes pack LSB-first into words written from address 0, one word in flight */
`timescale 1ns/1ps
`default_nettype none

module capture_ctrl (
    input  logic                           clock_spi_in,
    input  logic                           mipi_byte_reset_n,
    input  logic                           capture_start_i,
    input  logic                           pixel_frame_valid_i,
    input  logic                           pixel_line_valid_i,
    input  logic [cam_pkg::PIXEL_W-1:0]    pixel_data_i,
    input  logic                           wr_grant_i,
    output logic                           capture_busy_o,
    output logic [cam_pkg::BYTE_CNT_W-1:0] capture_bytes_o,
    output logic                           wr_req_o,
    output logic [cam_pkg::BUF_ADDR_W-1:0] wr_addr_o,
    output logic [31:0]                    wr_data_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT_GAP, ST_WAIT_FRAME, ST_CAPTURE} state_t;

    state_t                         state_q;
    logic                           lv_q;
    logic [cam_pkg::X_W-1:0]        x_q;
    logic [cam_pkg::Y_W-1:0]        y_q;
    logic [1:0]                     byte_idx_q;
    logic [23:0]                    pack_q;
    logic [31:0]                    hold_q;
    logic [cam_pkg::BUF_ADDR_W-1:0] word_addr_q;
    logic [7:0]                     pix8;
    logic                           in_window;
    logic                           take_pixel;
    logic                           word_done;

    assign pix8       = pixel_data_i[cam_pkg::PIXEL_W-1 -: 8];
    assign in_window  = pixel_line_valid_i &&
                        x_q >= cam_pkg::CROP_X_START && x_q < cam_pkg::CROP_X_END &&
                        y_q >= cam_pkg::CROP_Y_START && y_q < cam_pkg::CROP_Y_END;
    // First frame cycle still counts while the FSM moves into ST_CAPTURE
    assign take_pixel = in_window && (state_q == ST_CAPTURE ||
                        (state_q == ST_WAIT_FRAME && pixel_frame_valid_i));
    assign word_done  = take_pixel && byte_idx_q == 2'd3;

    assign capture_busy_o = capture_start_i || state_q != ST_IDLE;
    assign wr_addr_o      = word_addr_q;
    assign wr_data_o      = hold_q;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state_q         <= ST_IDLE;
            lv_q            <= 1'b0;
            x_q             <= '0;
            y_q             <= '0;
            byte_idx_q      <= '0;
            word_addr_q     <= '0;
            wr_req_o        <= 1'b0;
            capture_bytes_o <= '0;
        end else begin
            lv_q <= pixel_line_valid_i;
            x_q  <= pixel_line_valid_i ? x_q + 1'b1 : '0;
            if (!pixel_frame_valid_i) begin
                y_q <= '0;
            end else if (lv_q && !pixel_line_valid_i) begin
                y_q <= y_q + 1'b1;
            end

            case (state_q)
                ST_IDLE:       if (capture_start_i) state_q <= ST_WAIT_GAP;
                ST_WAIT_GAP:   if (!pixel_frame_valid_i) state_q <= ST_WAIT_FRAME;
                ST_WAIT_FRAME: if (pixel_frame_valid_i) state_q <= ST_CAPTURE;
                default:       if (!pixel_frame_valid_i) state_q <= ST_IDLE;
            endcase

            if (capture_start_i) begin
                byte_idx_q      <= '0;
                word_addr_q     <= '0;
                capture_bytes_o <= '0;
            end else begin
                if (take_pixel) byte_idx_q <= byte_idx_q + 1'b1;
                if (wr_grant_i) begin
                    word_addr_q     <= word_addr_q + 1'b1;
                    capture_bytes_o <= capture_bytes_o + 3'd4;
                end
            end

            if (wr_grant_i) wr_req_o <= 1'b0;
            if (word_done)  wr_req_o <= 1'b1;   // New word beats the grant clear
        end
    end

    always_ff @(posedge clock_spi_in) begin
        if (take_pixel && !word_done) pack_q[byte_idx_q*8 +: 8] <= pix8;
        if (word_done) hold_q <= {pix8, pack_q};   // Earliest pixel in bits 7:0
    end

    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        word_done |-> !(wr_req_o && !wr_grant_i))
        else $error("Word completed while the previous one still waits for a grant");

endmodule

`default_nettype wire

// File: rtl/cmd_decoder.sv
/* Op-code handler; the response is registered and drops one cycle after op_code_valid
   Read returns a prefetched byte, refilled after each operand strobe and after a capture */
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
    input  logic                           clock_spi_in,
    input  logic                           mipi_byte_reset_n,
    input  logic [7:0]                     op_code_i,
    input  logic                           op_code_valid_i,
    input  logic [7:0]                     operand_i,
    input  logic                           operand_valid_i,
    input  logic [7:0]                     operand_count_i,
    input  logic                           capture_busy_i,
    input  logic [cam_pkg::BYTE_CNT_W-1:0] capture_bytes_i,
    input  logic [7:0]                     meter_red_i,
    input  logic [7:0]                     meter_green_i,
    input  logic [7:0]                     meter_blue_i,
    input  logic                           rd_grant_i,
    input  logic [31:0]                    rd_data_i,
    input  logic                           rd_valid_i,
    output logic                           capture_start_o,
    output logic                           rd_req_o,
    output logic [cam_pkg::BUF_ADDR_W-1:0] rd_addr_o,
    output logic [7:0]                     response_o,
    output logic                           response_valid_o
);

    logic                           opv_q;
    logic                           operand_valid_q;
    logic                           busy_q;
    logic                           rd_pending_q;   // Granted, data not back yet
    logic [cam_pkg::BYTE_CNT_W-1:0] byte_ptr_q;
    logic [cam_pkg::BYTE_CNT_W-1:0] byte_ptr_next;
    logic [7:0]                     read_byte_q;
    logic                           read_strobe;

    assign byte_ptr_next = byte_ptr_q + 1'b1;
    assign read_strobe   = op_code_valid_i && op_code_i == cam_pkg::OP_READ &&
                           operand_valid_i && !operand_valid_q;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            opv_q            <= 1'b0;
            operand_valid_q  <= 1'b0;
            busy_q           <= 1'b0;
            rd_pending_q     <= 1'b0;
            byte_ptr_q       <= '0;
            capture_start_o  <= 1'b0;
            rd_req_o         <= 1'b0;
            rd_addr_o        <= '0;
            response_o       <= '0;
            response_valid_o <= 1'b0;
        end else begin
            opv_q           <= op_code_valid_i;
            operand_valid_q <= operand_valid_i;
            busy_q          <= capture_busy_i;

            capture_start_o <= op_code_valid_i && !opv_q &&
                               op_code_i == cam_pkg::OP_CAPTURE;
            if (op_code_valid_i && !opv_q && op_code_i == cam_pkg::OP_CAPTURE) begin
                byte_ptr_q <= '0;
            end

            if (rd_grant_i) begin
                rd_req_o     <= 1'b0;
                rd_pending_q <= 1'b1;
            end else if (rd_valid_i) begin
                rd_pending_q <= 1'b0;
            end

            if (busy_q && !capture_busy_i) begin   // Prefetch byte 0 after capture
                rd_req_o  <= 1'b1;
                rd_addr_o <= byte_ptr_q[cam_pkg::BUF_ADDR_W+1:2];
            end else if (read_strobe) begin
                byte_ptr_q <= byte_ptr_next;
                rd_req_o   <= 1'b1;
                rd_addr_o  <= byte_ptr_next[cam_pkg::BUF_ADDR_W+1:2];
            end

            response_valid_o <= op_code_valid_i;
            if (op_code_valid_i) begin
                case (op_code_i)
                    cam_pkg::OP_CAPTURE: response_o <= '0;
                    cam_pkg::OP_READ:    response_o <= read_byte_q;
                    cam_pkg::OP_METERING: begin
                        case (operand_count_i)
                            8'd0:    response_o <= meter_red_i;
                            8'd1:    response_o <= meter_green_i;
                            8'd2:    response_o <= meter_blue_i;
                            default: response_o <= '0;
                        endcase
                    end
                    cam_pkg::OP_SIZE: begin
                        case (operand_count_i)
                            8'd0:    response_o <= capture_bytes_i[7:0];
                            8'd1:    response_o <= capture_bytes_i[15:8];
                            default: response_o <= '0;
                        endcase
                    end
                    default: response_o <= operand_i;   // Echo for link checks
                endcase
            end
        end
    end

    // Byte lane picked by the pointer, byte 0 in bits 7:0
    always_ff @(posedge clock_spi_in) begin
        if (rd_valid_i && rd_pending_q) begin
            read_byte_q <= rd_data_i[byte_ptr_q[1:0]*8 +: 8];
        end
    end

    // The granted read is still in flight on the next cycle
    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        rd_grant_i |=> !rd_req_o)
        else $error("Read request raised while a read is outstanding");

endmodule

`default_nettype wire

// File: rtl/frame_metering.sv
/* Averages R, G and B over the fixed window on every frame, RGGB with red at (even, even)
   Outputs change only one cycle after frame-valid falls */
`timescale 1ns/1ps
`default_nettype none

module frame_metering (
    input  logic                        clock_spi_in,
    input  logic                        mipi_byte_reset_n,
    input  logic                        pixel_frame_valid_i,
    input  logic                        pixel_line_valid_i,
    input  logic [cam_pkg::PIXEL_W-1:0] pixel_data_i,
    output logic [7:0]                  meter_red_o,
    output logic [7:0]                  meter_green_o,
    output logic [7:0]                  meter_blue_o
);

    localparam int RED_W   = 8 + cam_pkg::RED_SHIFT;
    localparam int GREEN_W = 8 + cam_pkg::GREEN_SHIFT;
    localparam int BLUE_W  = 8 + cam_pkg::BLUE_SHIFT;

    logic                    lv_q;
    logic                    fv_q;
    logic [cam_pkg::X_W-1:0] x_q;
    logic [cam_pkg::Y_W-1:0] y_q;
    logic [RED_W-1:0]        red_sum_q;
    logic [GREEN_W-1:0]      green_sum_q;
    logic [BLUE_W-1:0]       blue_sum_q;
    logic [7:0]              pix8;
    logic                    in_window;
    logic                    frame_end;

    assign pix8      = pixel_data_i[cam_pkg::PIXEL_W-1 -: 8];
    assign frame_end = fv_q && !pixel_frame_valid_i;
    assign in_window = pixel_line_valid_i &&
                       x_q >= cam_pkg::CROP_X_START && x_q < cam_pkg::CROP_X_END &&
                       y_q >= cam_pkg::CROP_Y_START && y_q < cam_pkg::CROP_Y_END;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            lv_q          <= 1'b0;
            fv_q          <= 1'b0;
            x_q           <= '0;
            y_q           <= '0;
            red_sum_q     <= '0;
            green_sum_q   <= '0;
            blue_sum_q    <= '0;
            meter_red_o   <= '0;
            meter_green_o <= '0;
            meter_blue_o  <= '0;
        end else begin
            lv_q <= pixel_line_valid_i;
            fv_q <= pixel_frame_valid_i;
            x_q  <= pixel_line_valid_i ? x_q + 1'b1 : '0;
            if (!pixel_frame_valid_i) begin
                y_q <= '0;
            end else if (lv_q && !pixel_line_valid_i) begin
                y_q <= y_q + 1'b1;   // Line end
            end

            if (frame_end) begin
                meter_red_o   <= red_sum_q[RED_W-1:cam_pkg::RED_SHIFT];
                meter_green_o <= green_sum_q[GREEN_W-1:cam_pkg::GREEN_SHIFT];
                meter_blue_o  <= blue_sum_q[BLUE_W-1:cam_pkg::BLUE_SHIFT];
                red_sum_q     <= '0;
                green_sum_q   <= '0;
                blue_sum_q    <= '0;
            end else if (in_window) begin
                if (y_q[0] ^ x_q[0]) green_sum_q <= green_sum_q + pix8;
                else if (y_q[0])     blue_sum_q  <= blue_sum_q + pix8;
                else                 red_sum_q   <= red_sum_q + pix8;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/image_buffer.sv
/* Single-port RAM, read data one cycle after the address; no reset on contents */
`timescale 1ns/1ps
`default_nettype none

module image_buffer (
    input  logic                          clock_spi_in,
    input  logic [cam_pkg::BUF_ADDR_W-1:0] addr_i,
    input  logic [31:0]                   wdata_i,
    input  logic                          we_i,
    output logic [31:0]                   rdata_o
);

    logic [31:0] mem [2**cam_pkg::BUF_ADDR_W];

    always_ff @(posedge clock_spi_in) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];   // Old data on a write cycle
    end

endmodule

`default_nettype wire

// File: verif/tb_checks.svh
/* Compare tasks, waits and counters for tb_camera; outputs are sampled on the falling edge
   A timeout parks the calling thread and the watcher in tb_camera ends the run */

localparam int WAIT_LIMIT = 1000;       // Cycles, covers two full frames

int   error_count          = 0;
int   checks_run           = 0;
int   tests_run            = 0;
int   errors_at_test_start = 0;
logic timed_out            = 1'b0;

task automatic check_level(input string name, input logic got, input logic expected);
    checks_run++;
    if (got !== expected) begin
        error_count++;
        $display("Error: %s got 0x%h, expected 0x%h", name, got, expected);
    end
endtask

task automatic check_byte(input string name, input logic [7:0] got,
                          input logic [7:0] expected);
    checks_run++;
    if (got !== expected) begin
        error_count++;
        $display("Error: %s got 0x%h, expected 0x%h", name, got, expected);
    end
endtask

task automatic check_count(input string name, input logic [cam_pkg::BYTE_CNT_W-1:0] got,
                           input logic [cam_pkg::BYTE_CNT_W-1:0] expected);
    checks_run++;
    if (got !== expected) begin
        error_count++;
        $display("Error: %s got 0x%h, expected 0x%h", name, got, expected);
    end
endtask

task automatic halt_on_timeout(input string what);
    $display("Timeout: %s", what);
    timed_out = 1'b1;
    forever @(posedge clock_spi_in);   // Thread stays parked
endtask

task automatic wait_response_valid(input logic level);
    int cycles;
    cycles = 0;
    @(negedge clock_spi_in);
    while (response_valid_o !== level) begin
        if (cycles == WAIT_LIMIT) halt_on_timeout("response_valid_o never changed level");
        cycles++;
        @(negedge clock_spi_in);
    end
endtask

task automatic wait_capture_done();
    int cycles;
    cycles = 0;
    @(negedge clock_spi_in);
    while (u_camera_top.capture_busy !== 1'b0) begin
        if (cycles == WAIT_LIMIT) halt_on_timeout("capture never finished");
        cycles++;
        @(negedge clock_spi_in);
    end
endtask

task automatic report_test(input string name);
    tests_run++;
    $display("%-16s %s", name, (error_count == errors_at_test_start) ? "ok" : "FAILED");
    errors_at_test_start = error_count;
endtask

// File: verif/tb_camera.sv
/* Directed tests for camera_top on one 4 ns clock with seeded random 16x8 frames
   Frame timing is fixed: 2-cycle line gaps and a 4-cycle frame gap after each frame */
`timescale 1ns/1ps
`default_nettype none

module tb_camera;

    localparam int COLS      = 16;
    localparam int ROWS      = 8;
    localparam int WIN_W     = cam_pkg::CROP_X_END - cam_pkg::CROP_X_START;
    localparam int WIN_BYTES = WIN_W * (cam_pkg::CROP_Y_END - cam_pkg::CROP_Y_START);

    logic                        clock_spi_in = 1'b0;
    logic                        mipi_byte_reset_n;
    logic [7:0]                  op_code_i;
    logic                        op_code_valid_i;
    logic [7:0]                  operand_i;
    logic                        operand_valid_i;
    logic [7:0]                  operand_count_i;
    logic                        pixel_frame_valid_i;
    logic                        pixel_line_valid_i;
    logic [cam_pkg::PIXEL_W-1:0] pixel_data_i;
    logic [7:0]                  response_o;
    logic                        response_valid_o;
    logic [cam_pkg::PIXEL_W-1:0] frame_pix [2][ROWS][COLS];   // Two frame slots

    `include "tb_checks.svh"

    camera_top u_camera_top (.*);

    always #2 clock_spi_in = ~clock_spi_in;

    task automatic fill_frame(input int f);
        logic [31:0] rnd;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                rnd = $urandom();
                frame_pix[f][r][c] = rnd[cam_pkg::PIXEL_W-1:0];
            end
        end
    endtask

    task automatic drive_frame(input int f);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                @(posedge clock_spi_in);
                pixel_frame_valid_i <= 1'b1;
                pixel_line_valid_i  <= 1'b1;
                pixel_data_i        <= frame_pix[f][r][c];
            end
            repeat (2) begin
                @(posedge clock_spi_in);
                pixel_line_valid_i <= 1'b0;   // Line gap
            end
        end
        repeat (4) begin
            @(posedge clock_spi_in);
            pixel_frame_valid_i <= 1'b0;
        end
    endtask

    // Raster order over the window, upper 8 bits of each pixel
    function automatic logic [7:0] window_byte(input int f, input int idx);
        int row;
        int col;
        row = cam_pkg::CROP_Y_START + idx / WIN_W;
        col = cam_pkg::CROP_X_START + idx % WIN_W;
        return frame_pix[f][row][col][cam_pkg::PIXEL_W-1 -: 8];
    endfunction

    // Channel 0 red, 1 green, 2 blue
    function automatic logic [7:0] channel_avg(input int f, input int ch);
        int sum;
        int chan;
        int shift;
        sum = 0;
        for (int r = cam_pkg::CROP_Y_START; r < cam_pkg::CROP_Y_END; r++) begin
            for (int c = cam_pkg::CROP_X_START; c < cam_pkg::CROP_X_END; c++) begin
                if ((r % 2) != (c % 2)) chan = 1;
                else if (r % 2 == 1)    chan = 2;
                else                    chan = 0;
                if (chan == ch) sum += frame_pix[f][r][c][cam_pkg::PIXEL_W-1 -: 8];
            end
        end
        shift = (ch == 0) ? cam_pkg::RED_SHIFT :
                (ch == 1) ? cam_pkg::GREEN_SHIFT : cam_pkg::BLUE_SHIFT;
        return 8'(sum >> shift);
    endfunction

    // One command with one operand count, value taken with the first valid response
    task automatic query_byte(input logic [7:0] op, input logic [7:0] count,
                              output logic [7:0] value);
        @(posedge clock_spi_in);
        op_code_i       <= op;
        operand_count_i <= count;
        op_code_valid_i <= 1'b1;
        wait_response_valid(1'b1);
        value = response_o;
        @(posedge clock_spi_in);
        op_code_valid_i <= 1'b0;
        wait_response_valid(1'b0);
    endtask

    task automatic send_capture();
        logic [7:0] unused;
        query_byte(cam_pkg::OP_CAPTURE, 8'd0, unused);
    endtask

    task automatic check_metering(input int f);
        logic [7:0] value;
        for (int ch = 0; ch < 3; ch++) begin
            query_byte(cam_pkg::OP_METERING, 8'(ch), value);
            check_byte($sformatf("response_o metering ch%0d", ch), value, channel_avg(f, ch));
        end
    endtask

    task automatic read_back(input int f);
        @(posedge clock_spi_in);
        op_code_i       <= cam_pkg::OP_READ;
        operand_count_i <= 8'd0;
        op_code_valid_i <= 1'b1;
        wait_response_valid(1'b1);
        repeat (8) @(posedge clock_spi_in);
        for (int i = 0; i < WIN_BYTES; i++) begin
            @(negedge clock_spi_in);
            check_byte($sformatf("response_o byte %0d", i), response_o, window_byte(f, i));
            @(posedge clock_spi_in);
            operand_valid_i <= 1'b1;   // Advances to the next byte
            operand_count_i <= 8'(i);
            @(posedge clock_spi_in);
            operand_valid_i <= 1'b0;
            repeat (7) @(posedge clock_spi_in);
        end
        @(posedge clock_spi_in);
        op_code_valid_i <= 1'b0;
        wait_response_valid(1'b0);
    endtask

    task automatic test_reset_state();
        logic [7:0] value;
        @(negedge clock_spi_in);
        check_level("response_valid_o", response_valid_o, 1'b0);
        for (int ch = 0; ch < 3; ch++) begin
            query_byte(cam_pkg::OP_METERING, 8'(ch), value);
            check_byte($sformatf("response_o metering ch%0d", ch), value, 8'h00);
        end
        report_test("reset state");
    endtask

    task automatic test_metering();
        fill_frame(0);
        drive_frame(0);
        check_metering(0);
        report_test("metering");
    endtask

    task automatic test_capture_size();
        logic [7:0] lo;
        logic [7:0] hi;
        send_capture();
        drive_frame(0);
        drive_frame(0);
        wait_capture_done();
        query_byte(cam_pkg::OP_SIZE, 8'd0, lo);
        query_byte(cam_pkg::OP_SIZE, 8'd1, hi);
        check_count("response_o capture_bytes", {hi, lo}, WIN_BYTES);
        report_test("capture size");
    endtask

    task automatic test_readback();
        read_back(0);
        report_test("readback");
    endtask

    task automatic test_frame_select();
        fill_frame(1);
        fork
            begin
                drive_frame(0);   // Already running when the command lands
                drive_frame(1);
            end
            begin
                repeat (40) @(posedge clock_spi_in);
                send_capture();
            end
        join
        wait_capture_done();
        read_back(1);
        report_test("frame select");
    endtask

    task automatic test_recapture();
        fill_frame(0);
        send_capture();
        drive_frame(0);
        wait_capture_done();
        read_back(0);
        check_metering(0);
        report_test("recapture");
    endtask

    initial begin
        wait (timed_out);
        $display("Run stopped after %0d tests with %0d errors", tests_run, error_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(99306));
        mipi_byte_reset_n   = 1'b0;
        op_code_i           = '0;
        op_code_valid_i     = 1'b0;
        operand_i           = '0;
        operand_valid_i     = 1'b0;
        operand_count_i     = '0;
        pixel_frame_valid_i = 1'b0;
        pixel_line_valid_i  = 1'b0;
        pixel_data_i        = '0;
        repeat (2) @(posedge clock_spi_in);
        mipi_byte_reset_n <= 1'b1;

        test_reset_state();
        test_metering();
        test_capture_size();
        test_readback();
        test_frame_select();
        test_recapture();

        $display("Tests %0d, checks %0d, errors %0d", tests_run, checks_run, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
